// ==== verilog/mf2_pkg.sv ====
/*
  Shared definitions for the Multiface Two snapshot unit
  Store addresses follow the RAM layout of the Multiface Two
  Register offsets assume byte addressing on a 32-bit AXI4-Lite bus
*/

package mf2_pkg;

	// Unit mode as set over AXI
	typedef enum logic [1:0] {
		MODE_ENABLED  = 2'd0,
		MODE_HIDDEN   = 2'd1,
		MODE_DISABLED = 2'd2
	} mf2_mode_e;

	////////////////////////////////////////
	// Gate-array data byte

	typedef union packed {
		struct packed {
			logic [1:0] func;
			logic [5:0] payload;
		} cmd;
		struct packed {
			logic [1:0] func;
			logic       spare;
			logic       border;   // Selects border instead of a pen
			logic [3:0] pen;
		} pen;
	} ga_word_u;

	localparam logic [1:0] GA_FN_PEN  = 2'b00;
	localparam logic [1:0] GA_FN_INK  = 2'b01;
	localparam logic [1:0] GA_FN_MODE = 2'b10;
	localparam logic [1:0] GA_FN_BANK = 2'b11;

	////////////////////////////////////////
	// M1 fetch addresses and page port

	localparam logic [15:0] NMI_VECTOR     = 16'h0066;
	localparam logic [15:0] HIDE_VECTOR    = 16'h0065;
	localparam logic [13:0] PAGE_PORT_BASE = 14'h3FBA;   // FEE8 and FEEA

	////////////////////////////////////////
	// Shadow store addresses in the 8 KB RAM

	localparam logic [12:0] STORE_PEN_SEL   = 13'h1FCF;
	localparam logic [12:0] STORE_PEN_BASE  = 13'h1F90;   // 16 pen colours
	localparam logic [12:0] STORE_BORDER    = 13'h1FDF;
	localparam logic [12:0] STORE_MODE      = 13'h1FEF;
	localparam logic [12:0] STORE_BANK      = 13'h1FFF;
	localparam logic [12:0] STORE_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] STORE_CRTC_BASE = 13'h1DB0;   // 16 CRTC registers
	localparam logic [12:0] STORE_PPI       = 13'h17FF;
	localparam logic [12:0] STORE_UROM      = 13'h1AAC;

	// AXI register offsets
	localparam logic [3:0] REG_CTRL   = 4'h0;
	localparam logic [3:0] REG_STATUS = 4'h4;

endpackage

// ==== verilog/mf2_bus_if.sv ====
/*
  Z80-style CPU bus as seen by the MF2 unit
  io_wr_stb is a one-cycle pulse made from the rising edge of io_wr
*/

`timescale 1ns/1ps

interface mf2_bus_if;

	logic [15:0] cpu_addr;
	logic  [7:0] cpu_dout;    // CPU write data
	logic        m1;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;
	logic        io_wr_stb;   // Made by the paging block

	// Paging block owns the I/O write strobe
	modport ctrl (
		input  cpu_addr, cpu_dout, m1, io_wr, mem_rd, mem_wr,
		output io_wr_stb
	);

	// Shadow store only listens
	modport store (
		input cpu_addr, cpu_dout, m1, io_wr, mem_rd, mem_wr, io_wr_stb
	);

endinterface

// ==== verilog/mf2_config_regs.sv ====
/*
  AXI4-Lite register block for the MF2 unit, one transaction at a time
  Only address bits 3:0 are decoded, so AXI_ADDR_W must be at least 4
  CTRL[1:0] holds the mode; the value 3 is not a mode and is ignored
  STATUS is read-only with bit 0 paged in, bit 1 hidden and bit 2 NMI pending
*/

`timescale 1ns/1ps

module mf2_config_regs import mf2_pkg::*; #(
	parameter int AXI_ADDR_W = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  logic           [31:0] s_axi_wdata,
	input  logic            [3:0] s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic            [1:0] s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output logic           [31:0] s_axi_rdata,
	output logic            [1:0] s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,

	input  logic                  paged_in,
	input  logic                  hidden,
	input  logic                  nmi_pending,
	output mf2_mode_e             mode
);

	logic        bus_busy;   // Something accepted or awaiting its response
	logic        w_go;
	logic        r_go;
	logic [31:0] rd_word;

	assign bus_busy = s_axi_awready | s_axi_bvalid | s_axi_arready | s_axi_rvalid;

	// Writes win when both channels ask on the same cycle
	assign w_go = s_axi_awvalid & s_axi_wvalid & ~bus_busy;
	assign r_go = s_axi_arvalid & ~bus_busy & ~w_go;

	assign s_axi_bresp = 2'b00;   // Always OKAY
	assign s_axi_rresp = 2'b00;

	////////////////////////////////////////
	// Write channel

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s_axi_awready <= 1'b0;
			s_axi_wready  <= 1'b0;
			s_axi_bvalid  <= 1'b0;
			mode          <= MODE_ENABLED;
		end else begin
			s_axi_awready <= w_go;
			s_axi_wready  <= w_go;
			if (s_axi_awready) begin   // Handshake cycle
				s_axi_bvalid <= 1'b1;
				if (s_axi_awaddr[3:0] == REG_CTRL && s_axi_wstrb[0] &&
				    s_axi_wdata[1:0] != 2'b11) begin
					mode <= mf2_mode_e'(s_axi_wdata[1:0]);
				end
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Read channel

	always_comb begin
		case (s_axi_araddr[3:0])
			REG_CTRL:   rd_word = {30'd0, mode};
			REG_STATUS: rd_word = {29'd0, nmi_pending, hidden, paged_in};
			default:    rd_word = 32'd0;   // Unknown offsets
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid  <= 1'b0;
		end else begin
			s_axi_arready <= r_go;
			if (s_axi_arready)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	// Data is taken on the address handshake and held with rvalid
	always_ff @(posedge clk_sys) begin
		if (s_axi_arready)
			s_axi_rdata <= rd_word;
	end

endmodule

// ==== verilog/mf2_paging_ctrl.sv ====
/*
  NMI arming and page control of the MF2 unit
  Edges of m1, io_wr and the button act one clock after the input rises
  The hidden flag takes the mode only at reset; later it follows the CPU
*/

`timescale 1ns/1ps

module mf2_paging_ctrl import mf2_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	mf2_bus_if.ctrl   bus,
	input  logic      nmi_button,
	input  mf2_mode_e mode,
	output logic      nmi,
	output logic      paged_in,
	output logic      hidden,
	output logic      ram_en,
	output logic      rom_en
);

	logic btn_q;
	logic m1_q;
	logic io_wr_q;
	logic btn_edge;
	logic m1_edge;

	////////////////////////////////////////
	// Edge detect with registered pulses

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn_q         <= 1'b0;
			m1_q          <= 1'b0;
			io_wr_q       <= 1'b0;
			btn_edge      <= 1'b0;
			m1_edge       <= 1'b0;
			bus.io_wr_stb <= 1'b0;
		end else begin
			btn_q         <= nmi_button;
			m1_q          <= bus.m1;
			io_wr_q       <= bus.io_wr;
			btn_edge      <= nmi_button & ~btn_q;
			m1_edge       <= bus.m1 & ~m1_q;
			bus.io_wr_stb <= bus.io_wr & ~io_wr_q;
		end
	end

	////////////////////////////////////////
	// Paging state

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi      <= 1'b0;
			paged_in <= 1'b0;
			hidden   <= (mode != MODE_ENABLED);
		end else begin
			if (btn_edge && !paged_in && mode != MODE_DISABLED)
				nmi <= 1'b1;

			// NMI handler fetch pages the unit in
			if (m1_edge && nmi && bus.cpu_addr == NMI_VECTOR) begin
				paged_in <= 1'b1;
				hidden   <= 1'b0;
				nmi      <= 1'b0;
			end
			if (m1_edge && paged_in && bus.cpu_addr == HIDE_VECTOR)
				hidden <= 1'b1;

			// FEEA pages out, FEE8 pages in unless hidden
			if (bus.io_wr_stb && bus.cpu_addr[15:2] == PAGE_PORT_BASE)
				paged_in <= ~bus.cpu_addr[1] & ~hidden;
		end
	end

	assign rom_en = paged_in & (bus.cpu_addr[15:13] == 3'b000);   // 0000-1FFF
	assign ram_en = paged_in & (bus.cpu_addr[15:13] == 3'b001);   // 2000-3FFF

endmodule

// ==== verilog/mf2_shadow_store.sv ====
/*
  Shadow capture of write-only CPC registers and the MF2 8 KB RAM
  Captures happen on every I/O write, paged in or not
  Addresses must stay stable for three clocks around each access
*/

`timescale 1ns/1ps

module mf2_shadow_store import mf2_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	mf2_bus_if.store   bus,
	input  logic       ram_en,
	output logic [7:0] cpu_din
);

	// High address byte of the captured ports
	localparam logic [7:0] PORT_GA        = 8'h7F;
	localparam logic [7:0] PORT_CRTC_SEL  = 8'hBC;
	localparam logic [7:0] PORT_CRTC_DATA = 8'hBD;
	localparam logic [7:0] PORT_PPI       = 8'hF7;
	localparam logic [7:0] PORT_UROM      = 8'hDF;

	ga_word_u    ga;
	logic  [4:0] pen_index;    // Bit 4 selects the border
	logic  [3:0] crtc_index;
	logic [12:0] store_addr;
	logic        capture;

	logic  [7:0] ram [0:8191];
	logic [12:0] ram_a;
	logic  [7:0] ram_in;
	logic        ram_we;
	logic  [7:0] ram_q;

	assign ga = bus.cpu_dout;

	////////////////////////////////////////
	// Store address decode

	always_comb begin
		case (bus.cpu_addr[15:8])
			PORT_GA: begin
				case (ga.cmd.func)
					GA_FN_PEN:  store_addr = STORE_PEN_SEL;
					GA_FN_INK:  store_addr = pen_index[4] ? STORE_BORDER :
					                         STORE_PEN_BASE | {9'd0, pen_index[3:0]};
					GA_FN_MODE: store_addr = STORE_MODE;
					default:    store_addr = STORE_BANK;
				endcase
			end
			PORT_CRTC_SEL:  store_addr = STORE_CRTC_SEL;
			PORT_CRTC_DATA: store_addr = STORE_CRTC_BASE | {9'd0, crtc_index};
			PORT_PPI:       store_addr = STORE_PPI;
			PORT_UROM:      store_addr = STORE_UROM;
			default:        store_addr = 13'd0;   // Not a shadowed port
		endcase
	end

	assign capture = bus.io_wr_stb & (|store_addr);

	////////////////////////////////////////
	// Index tracking and write request

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index  <= 5'd0;
			crtc_index <= 4'd0;
			ram_we     <= 1'b0;
		end else if (capture) begin
			if (bus.cpu_addr[15:8] == PORT_GA && ga.cmd.func == GA_FN_PEN)
				pen_index <= {ga.pen.border, ga.pen.pen};
			if (bus.cpu_addr[15:8] == PORT_CRTC_SEL)
				crtc_index <= ga.cmd.payload[3:0];
			ram_we <= 1'b1;
		end else begin
			ram_we <= bus.mem_wr & ram_en;   // Plain CPU write
		end
	end

	// Address and data follow the CPU unless a capture is in progress
	always_ff @(posedge clk_sys) begin
		ram_a  <= capture ? store_addr : bus.cpu_addr[12:0];
		ram_in <= bus.cpu_dout;
	end

	////////////////////////////////////////
	// RAM is write-first with a registered output

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_q      <= ram_in;
		end else begin
			ram_q <= ram[ram_a];
		end
	end

	// Open bus reads as FF
	assign cpu_din = (bus.mem_rd & ram_en) ? ram_q : 8'hFF;

endmodule

// ==== verilog/mf2_top.sv ====
/*
  Multiface Two snapshot unit on a Z80-style bus
  ROM contents live outside, only rom_en is given for 0000-1FFF
  cpu_din is FF whenever the unit does not drive the bus
*/

`timescale 1ns/1ps

module mf2_top import mf2_pkg::*; #(
	parameter int AXI_ADDR_W = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	// AXI4-Lite configuration slave
	input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  logic           [31:0] s_axi_wdata,
	input  logic            [3:0] s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic            [1:0] s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output logic           [31:0] s_axi_rdata,
	output logic            [1:0] s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,

	// CPU bus
	input  logic           [15:0] cpu_addr,
	input  logic            [7:0] cpu_dout,
	input  logic                  m1,
	input  logic                  io_wr,
	input  logic                  mem_rd,
	input  logic                  mem_wr,
	input  logic                  nmi_button,

	output logic                  nmi,
	output logic                  rom_en,
	output logic                  ram_en,
	output logic            [7:0] cpu_din
);

	mf2_mode_e mode;
	logic      paged_in;
	logic      hidden;

	mf2_bus_if bus ();

	assign bus.cpu_addr = cpu_addr;
	assign bus.cpu_dout = cpu_dout;
	assign bus.m1       = m1;
	assign bus.io_wr    = io_wr;
	assign bus.mem_rd   = mem_rd;
	assign bus.mem_wr   = mem_wr;

	mf2_config_regs #(.AXI_ADDR_W(AXI_ADDR_W)) i_config (
		.clk_sys, .reset,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
		.s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
		.s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
		.s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
		.paged_in, .hidden, .nmi_pending(nmi), .mode
	);

	mf2_paging_ctrl i_paging (
		.clk_sys, .reset, .bus(bus.ctrl), .nmi_button, .mode,
		.nmi, .paged_in, .hidden, .ram_en, .rom_en
	);

	mf2_shadow_store i_store (
		.clk_sys, .reset, .bus(bus.store), .ram_en, .cpu_din
	);

endmodule

// ==== tests/mf2_checker.sv ====
/*
  Reference model and scoreboard for the MF2 unit
  Watches the DUT ports only, samples on the rising clock edge
  Bus operations must be held exactly HOLD_CYCLES clocks
*/

`timescale 1ns/1ps

module mf2_checker import mf2_pkg::*; #(
	parameter int AXI_ADDR_W  = 4,
	parameter int HOLD_CYCLES = 4
) (
	input logic                  clk_sys,
	input logic                  reset,
	input logic [AXI_ADDR_W-1:0] s_axi_awaddr,
	input logic [AXI_ADDR_W-1:0] s_axi_araddr,
	input logic           [31:0] s_axi_wdata,
	input logic           [31:0] s_axi_rdata,
	input logic            [1:0] s_axi_bresp,
	input logic            [1:0] s_axi_rresp,
	input logic                  s_axi_awready,
	input logic                  s_axi_wready,
	input logic                  s_axi_bvalid,
	input logic                  s_axi_bready,
	input logic                  s_axi_arready,
	input logic                  s_axi_rvalid,
	input logic                  s_axi_rready,
	input logic           [15:0] cpu_addr,
	input logic            [7:0] cpu_dout,
	input logic            [7:0] cpu_din,
	input logic                  m1,
	input logic                  io_wr,
	input logic                  mem_rd,
	input logic                  mem_wr,
	input logic                  nmi_button,
	input logic                  nmi,
	input logic                  rom_en,
	input logic                  ram_en
);

	int          errors = 0;
	int          checks = 0;
	mf2_mode_e   mode;
	logic        nmi_m;
	logic        paged;
	logic        hidden_m;
	logic  [4:0] pen_idx;     // Border flag on top
	logic  [3:0] crtc_idx;
	logic  [7:0] shadow [0:8191];
	logic [31:0] rd_exp;
	logic        m1_q, io_q, wr_q, btn_q;
	int          hold;

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at time %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	// Port write as seen by the shadow logic and the page port
	task automatic io_write_model(input logic [15:0] a, input logic [7:0] d);
		ga_word_u w;
		w = d;
		case (a[15:8])
			8'h7F: begin
				case (w.cmd.func)
					GA_FN_PEN: begin
						pen_idx = {w.pen.border, w.pen.pen};
						shadow[STORE_PEN_SEL] = d;
					end
					GA_FN_INK: shadow[pen_idx[4] ? STORE_BORDER : STORE_PEN_BASE + pen_idx[3:0]] = d;
					GA_FN_MODE: shadow[STORE_MODE] = d;
					default:    shadow[STORE_BANK] = d;
				endcase
			end
			8'hBC: begin
				crtc_idx = d[3:0];
				shadow[STORE_CRTC_SEL] = d;
			end
			8'hBD: shadow[STORE_CRTC_BASE + crtc_idx] = d;
			8'hF7: shadow[STORE_PPI] = d;
			8'hDF: shadow[STORE_UROM] = d;
			default: ;
		endcase
		if (a[15:2] == PAGE_PORT_BASE) begin
			if (a[1])
				paged = 1'b0;
			else if (!hidden_m)
				paged = 1'b1;
		end
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			mode     = MODE_ENABLED;
			nmi_m    = 1'b0;
			paged    = 1'b0;
			hidden_m = 1'b0;
			pen_idx  = 5'd0;
			crtc_idx = 4'd0;
			{m1_q, io_q, wr_q, btn_q} = 4'b0;
			hold     = 0;
		end else begin
			////////////////////////////////////////
			// AXI side

			if (s_axi_awready || s_axi_wready)
				check_value("AXI wready with awready", s_axi_awready, s_axi_wready);
			if (s_axi_awready && s_axi_awaddr[3:0] == REG_CTRL)
				mode = mf2_mode_e'(s_axi_wdata[1:0]);
			if (s_axi_bvalid && s_axi_bready)
				check_value("AXI write response", 32'd0, s_axi_bresp);
			if (s_axi_arready) begin
				case (s_axi_araddr[3:0])
					REG_CTRL:   rd_exp = {30'd0, mode};
					REG_STATUS: rd_exp = {29'd0, nmi_m, hidden_m, paged};
					default:    rd_exp = 32'd0;
				endcase
			end
			if (s_axi_rvalid && s_axi_rready) begin
				check_value("AXI read data", rd_exp, s_axi_rdata);
				check_value("AXI read response", 32'd0, s_axi_rresp);
			end

			////////////////////////////////////////
			// CPU bus side where state moves on rising strobes

			if (nmi_button && !btn_q && !paged && mode != MODE_DISABLED)
				nmi_m = 1'b1;
			if (m1 && !m1_q) begin
				if (nmi_m && cpu_addr == NMI_VECTOR) begin
					paged    = 1'b1;
					hidden_m = 1'b0;
					nmi_m    = 1'b0;
				end else if (paged && cpu_addr == HIDE_VECTOR) begin
					hidden_m = 1'b1;
				end
			end
			if (io_wr && !io_q)
				io_write_model(cpu_addr, cpu_dout);
			if (mem_wr && !wr_q && paged && cpu_addr[15:13] == 3'd1)
				shadow[cpu_addr[12:0]] = cpu_dout;
			{m1_q, io_q, wr_q, btn_q} = {m1, io_wr, mem_wr, nmi_button};

			hold = (m1 | io_wr | mem_rd | mem_wr | nmi_button) ? hold + 1 : 0;
			if (hold == HOLD_CYCLES) begin   // Last held cycle
				check_value("nmi", nmi_m, nmi);
				check_value("rom_en", paged && cpu_addr[15:13] == 3'd0, rom_en);
				check_value("ram_en", paged && cpu_addr[15:13] == 3'd1, ram_en);
				if (mem_rd)
					check_value("cpu_din", (paged && cpu_addr[15:13] == 3'd1) ?
					            shadow[cpu_addr[12:0]] : 8'hFF, cpu_din);
			end
		end
	end

endmodule

// ==== tests/mf2_tb.sv ====
/*
  Testbench for the MF2 unit, random stimulus from a fixed seed
  Bus operations are held four clocks with two idle clocks after each
  Inputs change on the falling edge, the checker samples on the rising edge
*/

`timescale 1ns/1ps

module mf2_tb import mf2_pkg::*; ();

	localparam int AXI_ADDR_W = 4;
	localparam int HOLD       = 4;     // Clocks per bus operation
	localparam int AXI_WAIT   = 20;
	localparam int N_CFG      = 12;
	localparam int N_CAP      = 64;
	localparam int N_RAM      = 160;
	localparam int N_OPS      = 3 * N_CFG + N_CAP + N_RAM + 220;   // Bound over all tests
	localparam int TIMEOUT_NS = N_OPS * 12 * 4 + 1000;

	localparam int OP_M1 = 0;
	localparam int OP_IO = 1;
	localparam int OP_RD = 2;
	localparam int OP_WR = 3;
	localparam int OP_BTN = 4;

	localparam logic [15:0] PORT_IN   = {PAGE_PORT_BASE, 2'b00};
	localparam logic [15:0] PORT_OUT  = {PAGE_PORT_BASE, 2'b10};
	localparam logic [39:0] CAP_PORTS = 40'h7F_BC_BD_F7_DF;

	logic                  clk_sys, reset;
	logic [AXI_ADDR_W-1:0] s_axi_awaddr, s_axi_araddr;
	logic           [31:0] s_axi_wdata, s_axi_rdata;
	logic            [3:0] s_axi_wstrb;
	logic            [1:0] s_axi_bresp, s_axi_rresp;
	logic                  s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
	logic                  s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
	logic                  s_axi_rvalid, s_axi_rready;
	logic           [15:0] cpu_addr;
	logic            [7:0] cpu_dout, cpu_din;
	logic                  m1, io_wr, mem_rd, mem_wr, nmi_button;
	logic                  nmi, rom_en, ram_en;

	int resp_errors = 0;
	int errs_before = 0;
	int test_no     = 1;

	mf2_top #(.AXI_ADDR_W(AXI_ADDR_W)) i_dut (.*);
	mf2_checker #(.AXI_ADDR_W(AXI_ADDR_W), .HOLD_CYCLES(HOLD)) i_chk (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic axi_flag(input int sel);
		case (sel)
			0:       return s_axi_awready;
			1:       return s_axi_bvalid;
			2:       return s_axi_arready;
			default: return s_axi_rvalid;
		endcase
	endfunction

	// Waits for the flag, then one more edge so the handshake completes
	task automatic await_handshake(input int sel, input string what);
		int n;
		n = 0;
		while (!axi_flag(sel) && n < AXI_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!axi_flag(sel)) begin
			resp_errors++;
			$display("No %s from the DUT within %0d cycles at time %0t", what, AXI_WAIT, $time);
		end
		@(negedge clk_sys);
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		s_axi_awaddr  = addr;
		s_axi_wdata   = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid  = 1'b1;
		s_axi_bready  = 1'b1;
		await_handshake(0, "write address ready");
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		await_handshake(1, "write response");
		s_axi_bready  = 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr);
		s_axi_araddr  = addr;
		s_axi_arvalid = 1'b1;
		s_axi_rready  = 1'b1;
		await_handshake(2, "read address ready");
		s_axi_arvalid = 1'b0;
		await_handshake(3, "read data");
		s_axi_rready  = 1'b0;
	endtask

	task automatic bus_op(input int kind, input logic [15:0] addr, input logic [7:0] data);
		cpu_addr   = addr;
		cpu_dout   = data;
		m1         = (kind == OP_M1);
		io_wr      = (kind == OP_IO);
		mem_rd     = (kind == OP_RD);
		mem_wr     = (kind == OP_WR);
		nmi_button = (kind == OP_BTN);
		repeat (HOLD) @(negedge clk_sys);
		{m1, io_wr, mem_rd, mem_wr, nmi_button} = 5'b0;
		repeat (2) @(negedge clk_sys);   // Idle gap
	endtask

	task automatic read_shadow(input logic [12:0] a);
		bus_op(OP_RD, {3'b001, a}, 8'h00);
	endtask

	task automatic enter_unit();
		bus_op(OP_BTN, 16'h0000, 8'h00);
		bus_op(OP_M1, NMI_VECTOR, 8'h00);
	endtask

	task automatic end_test(input string name);
		int total;
		total = i_chk.errors + resp_errors;
		$display("Test %0d %s finished with %0d errors", test_no, name, total - errs_before);
		errs_before = total;
		test_no++;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog stopped the run after %0d ns, the tests did not complete", TIMEOUT_NS);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [31:0]  r;
		logic  [4:0]  k;
		logic [12:0]  a;
		logic [12:0]  written [$];

		void'($urandom(96357));
		reset = 1'b1;
		{s_axi_awaddr, s_axi_araddr, s_axi_wdata} = '0;
		s_axi_wstrb = 4'hF;
		{s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = 5'b0;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		{m1, io_wr, mem_rd, mem_wr, nmi_button} = 5'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		// Register block
		axi_read(REG_STATUS);
		axi_read(REG_CTRL);
		axi_read(4'h8);
		axi_read(4'hC);
		repeat (N_CFG) begin
			axi_write(REG_CTRL, $urandom_range(2));
			axi_read(REG_CTRL);
		end
		axi_write(REG_STATUS, 32'h7);
		axi_read(REG_STATUS);
		axi_write(REG_CTRL, MODE_ENABLED);
		axi_read(REG_CTRL);
		end_test("configuration");

		// NMI entry and decode ranges
		bus_op(OP_BTN, 16'h0000, 8'h00);
		axi_read(REG_STATUS);
		bus_op(OP_M1, NMI_VECTOR, 8'h00);
		axi_read(REG_STATUS);
		bus_op(OP_RD, 16'h0100, 8'h00);
		bus_op(OP_WR, 16'h2100, 8'h5A);
		bus_op(OP_RD, 16'h2100, 8'h00);
		bus_op(OP_RD, 16'h4000, 8'h00);
		bus_op(OP_IO, PORT_OUT, 8'h00);
		axi_write(REG_CTRL, MODE_DISABLED);
		bus_op(OP_BTN, 16'h0000, 8'h00);
		axi_read(REG_STATUS);
		axi_write(REG_CTRL, MODE_ENABLED);
		end_test("nmi entry");

		// Page port and hiding
		enter_unit();
		axi_read(REG_STATUS);
		bus_op(OP_IO, PORT_OUT, 8'h00);
		axi_read(REG_STATUS);
		bus_op(OP_IO, PORT_IN, 8'h00);
		axi_read(REG_STATUS);
		bus_op(OP_M1, HIDE_VECTOR, 8'h00);
		axi_read(REG_STATUS);
		bus_op(OP_IO, PORT_OUT, 8'h00);
		bus_op(OP_IO, PORT_IN, 8'h00);   // Stays out while hidden
		axi_read(REG_STATUS);
		enter_unit();
		bus_op(OP_IO, PORT_OUT, 8'h00);
		bus_op(OP_IO, PORT_IN, 8'h00);
		axi_read(REG_STATUS);
		end_test("page port and hiding");

		// Shadow capture with every store address written at least once
		bus_op(OP_IO, PORT_OUT, 8'h00);
		for (k = 0; k < 17; k++) begin
			r = $urandom;
			bus_op(OP_IO, 16'h7F00, (k == 16) ? 8'h10 : {4'h0, k[3:0]});
			bus_op(OP_IO, 16'h7F00, {2'b01, r[5:0]});
		end
		for (k = 0; k < 16; k++) begin
			r = $urandom;
			bus_op(OP_IO, 16'hBC00, {4'h0, k[3:0]});
			bus_op(OP_IO, 16'hBD00, r[7:0]);
		end
		r = $urandom;
		bus_op(OP_IO, 16'h7F00, {2'b10, r[5:0]});
		bus_op(OP_IO, 16'h7F00, {2'b11, r[13:8]});
		bus_op(OP_IO, 16'hF700, r[23:16]);
		bus_op(OP_IO, 16'hDF00, r[31:24]);
		repeat (N_CAP) begin
			r = $urandom;
			bus_op(OP_IO, {CAP_PORTS[8 * $urandom_range(4) +: 8], r[7:0]}, r[15:8]);
		end
		enter_unit();
		read_shadow(STORE_PEN_SEL);
		read_shadow(STORE_BORDER);
		read_shadow(STORE_MODE);
		read_shadow(STORE_BANK);
		read_shadow(STORE_CRTC_SEL);
		read_shadow(STORE_PPI);
		read_shadow(STORE_UROM);
		for (k = 0; k < 16; k++) begin
			read_shadow(STORE_PEN_BASE + k[3:0]);
			read_shadow(STORE_CRTC_BASE + k[3:0]);
		end
		end_test("shadow capture");

		// Shadow RAM through the CPU window
		repeat (N_RAM) begin
			r = $urandom;
			a = r[12:0];
			if (r[14:13] == 2'd0 || written.size() == 0) begin
				bus_op(OP_WR, {3'b001, a}, r[23:16]);
				written.push_back(a);
			end else if (r[14:13] == 2'd3) begin
				bus_op(OP_RD, {1'b1, r[30:16]}, 8'h00);   // Outside the window
			end else begin
				read_shadow(written[$urandom_range(written.size() - 1)]);
			end
		end
		bus_op(OP_IO, PORT_OUT, 8'h00);
		repeat (8) read_shadow(written[$urandom_range(written.size() - 1)]);
		end_test("shadow ram");

		$display("Checks %0d, AXI response errors %0d, total errors %0d",
		         i_chk.checks, resp_errors, i_chk.errors + resp_errors);
		if (i_chk.errors + resp_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/mf2_pkg.sv
verilog/mf2_bus_if.sv
verilog/mf2_config_regs.sv
verilog/mf2_paging_ctrl.sv
verilog/mf2_shadow_store.sv
verilog/mf2_top.sv
tests/mf2_checker.sv
tests/mf2_tb.sv

// ==== Bender.yml ====
package:
  name: mf2_snapshot

sources:
  - verilog/mf2_pkg.sv
  - verilog/mf2_bus_if.sv
  - verilog/mf2_config_regs.sv
  - verilog/mf2_paging_ctrl.sv
  - verilog/mf2_shadow_store.sv
  - verilog/mf2_top.sv
  - target: test
    files:
      - tests/mf2_checker.sv
      - tests/mf2_tb.sv
